// ==== design/pcxt_glue_pkg.sv ====
`default_nettype none

package pcxt_glue_pkg;

	//////////////////////////////////////////////////
	// bus and sample widths
	//////////////////////////////////////////////////

	localparam int axi_addr_w = 4; // four word slots
	localparam int axi_data_w = 32;
	localparam int sample_w   = 16; // signed audio samples

	//////////////////////////////////////////////////
	// register map, byte offsets
	//////////////////////////////////////////////////

	// bit 0 turbo request, bit 1 soft reset strobe
	localparam logic [axi_addr_w-1:0] reg_control   = 4'h0;
	localparam logic [axi_addr_w-1:0] reg_dip       = 4'h4; // dip switches
	localparam logic [axi_addr_w-1:0] reg_status    = 4'h8; // read only
	localparam logic [axi_addr_w-1:0] reg_mix_level = 4'hC; // read only

	//////////////////////////////////////////////////
	// responses and power-up values
	//////////////////////////////////////////////////

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// pc/xt switch block
	// cga 80 columns, 640k, one floppy
	localparam logic [7:0] dip_default = 8'h2D;

endpackage

`default_nettype wire

// ==== design/reset_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
	parameter int unsigned reset_hold      = 65535, // edges of sys reset after release
	parameter int unsigned cpu_reset_delay = 42     // extra edges before cpu runs
) (
	input  wire  clk_chipset,
	input  wire  reset_wire,  // board reset, async
	input  wire  soft_reset,  // one cycle strobe from regs
	output logic sys_reset,
	output logic cpu_reset
);

	// last count values
	localparam logic [15:0] hold_last = 16'(reset_hold - 1);
	localparam logic [15:0] cpu_last  = 16'(cpu_reset_delay);

	logic [15:0] hold_cnt; // system hold counter
	logic [15:0] cpu_cnt;  // cpu release delay

	//////////////////////////////////////////////////
	// system reset hold
	//////////////////////////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			sys_reset <= 1'b1;
			hold_cnt  <= '0;
		end else if (soft_reset) begin // same as board reset, but sync
			sys_reset <= 1'b1;
			hold_cnt  <= '0;
		end else if (sys_reset) begin
			if (hold_cnt == hold_last)
				sys_reset <= 1'b0; // hold done
			else
				hold_cnt <= hold_cnt + 16'd1;
		end
	end

	//////////////////////////////////////////////////
	// delayed cpu release
	//////////////////////////////////////////////////

	// counter only runs once sys_reset is low
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_reset <= 1'b1;
			cpu_cnt   <= '0;
		end else if (soft_reset || sys_reset) begin
			cpu_reset <= 1'b1; // keep cpu parked
			cpu_cnt   <= '0;
		end else if (cpu_reset) begin
			if (cpu_cnt == cpu_last)
				cpu_reset <= 1'b0;
			else
				cpu_cnt <= cpu_cnt + 16'd1;
		end
	end

endmodule

`default_nettype wire

// ==== design/frac_clock_enable.sv ====
`timescale 1ns/1ps
`default_nettype none

module frac_clock_enable #(
	parameter int unsigned increment = 358,  // added per cycle
	parameter int unsigned modulus   = 5000, // wrap point
	parameter int unsigned divide    = 1     // post divider, 1 means none
) (
	input  wire  clk_chipset,
	input  wire  sys_reset,
	output logic clk_en
);

	// sum never exceeds modulus - 1 + increment
	localparam int unsigned acc_w = $clog2(modulus + increment);
	localparam logic [acc_w-1:0] acc_inc = acc_w'(increment);
	localparam logic [acc_w-1:0] acc_mod = acc_w'(modulus);

	logic [acc_w-1:0] acc;
	logic [acc_w-1:0] acc_sum;
	logic             raw_pulse; // one per wrap

	assign acc_sum = acc + acc_inc;

	// phase accumulator
	always_ff @(posedge clk_chipset or posedge sys_reset) begin
		if (sys_reset) begin
			acc       <= '0;
			raw_pulse <= 1'b0;
		end else if (acc_sum >= acc_mod) begin
			acc       <= acc_sum - acc_mod; // keep the remainder
			raw_pulse <= 1'b1;
		end else begin
			acc       <= acc_sum;
			raw_pulse <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// post divider
	//////////////////////////////////////////////////

	generate
		if (divide > 1) begin : g_post_div
			localparam int unsigned div_w = $clog2(divide);
			localparam logic [div_w-1:0] div_last = div_w'(divide - 1);

			logic [div_w-1:0] div_cnt; // raw pulses seen, mod divide

			always_ff @(posedge clk_chipset or posedge sys_reset) begin
				if (sys_reset)
					div_cnt <= '0;
				else if (raw_pulse)
					div_cnt <= (div_cnt == div_last) ? '0 : div_cnt + div_w'(1);
			end

			assign clk_en = raw_pulse & (div_cnt == div_last); // every divide-th
		end else begin : g_no_div
			assign clk_en = raw_pulse;
		end
	endgenerate

endmodule

`default_nettype wire

// ==== design/audio_mixer_dac.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_mixer_dac
	import pcxt_glue_pkg::*;
(
	input  wire                 clk_chipset,
	input  wire                 sys_reset,
	input  wire  [sample_w-1:0] opl_sample,   // fm chip, signed
	input  wire  [sample_w-1:0] tandy_sample, // tandy sound, signed
	input  wire                 speaker,      // pc speaker bit
	output logic [sample_w-1:0] mix_level,    // clamped mix, signed
	output logic                audio_out     // one bit stream
);

	localparam int sum_w = sample_w + 1; // one guard bit

	//////////////////////////////////////////////////
	// scale and sum
	//////////////////////////////////////////////////

	logic signed [sum_w-1:0] opl_term;
	logic signed [sum_w-1:0] tandy_term;
	logic signed [sum_w-1:0] spk_term;
	logic signed [sum_w-1:0] mix_sum;
	logic        [sample_w-1:0] mix_clamped;

	assign opl_term   = {opl_sample, 1'b0};                // x2
	assign tandy_term = {tandy_sample[sample_w-6:0], 6'd0}; // x64, wraps in 17 bits
	assign spk_term   = sum_w'({speaker, 13'd0});          // x8192
	assign mix_sum    = opl_term + tandy_term + spk_term;

	// saturate when the top two bits differ
	assign mix_clamped = (mix_sum[sum_w-1] == mix_sum[sum_w-2]) ?
		mix_sum[sample_w-1:0] :
		{mix_sum[sum_w-1], {(sample_w-1){~mix_sum[sum_w-1]}}};

	always_ff @(posedge clk_chipset or posedge sys_reset) begin
		if (sys_reset)
			mix_level <= '0;
		else
			mix_level <= mix_clamped;
	end

	//////////////////////////////////////////////////
	// first order sigma-delta
	//////////////////////////////////////////////////

	logic [31:0]         integ;      // leaky integrator
	logic [sample_w-1:0] dac_level;  // offset binary
	logic                dac_bit;

	assign dac_level = {~mix_level[sample_w-1], mix_level[sample_w-2:0]}; // flip sign
	assign dac_bit   = integ[31:16] < dac_level;

	// leak 1/128 per cycle, kick of 2^25 per high bit
	always_ff @(posedge clk_chipset or posedge sys_reset) begin
		if (sys_reset) begin
			integ     <= '0;
			audio_out <= 1'b0;
		end else begin
			integ     <= integ - {7'd0, integ[31:7]} + (32'(dac_bit) << 25);
			audio_out <= dac_bit;
		end
	end

endmodule

`default_nettype wire

// ==== design/glue_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module glue_ctrl_regs
	import pcxt_glue_pkg::*;
(
	input  wire                     clk_chipset,
	input  wire                     reset_wire,
	// axi4-lite write side
	input  wire  [axi_addr_w-1:0]   awaddr,
	input  wire                     awvalid,
	output logic                    awready,
	input  wire  [axi_data_w-1:0]   wdata,
	input  wire  [axi_data_w/8-1:0] wstrb,
	input  wire                     wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  wire                     bready,
	// axi4-lite read side
	input  wire  [axi_addr_w-1:0]   araddr,
	input  wire                     arvalid,
	output logic                    arready,
	output logic [axi_data_w-1:0]   rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  wire                     rready,
	// chipset side
	input  wire                     cpu_reset,
	input  wire  [sample_w-1:0]     mix_level,
	input  wire                     biu_done,   // cpu bus cycle finished
	input  wire  [7:0]              port_b_out, // kbd controller port b
	output logic                    soft_reset,
	output logic                    turbo_mode,
	output logic [3:0]              port_c_low
);

	logic                  turbo_request; // sw side, waits for biu_done
	logic [7:0]            dip_sw;
	logic                  wr_accept;
	logic                  rd_accept;
	logic                  wr_control;
	logic                  wr_dip;
	logic [axi_data_w-1:0] rd_data;
	logic                  rd_mapped;

	//////////////////////////////////////////////////
	// write channel
	//////////////////////////////////////////////////

	assign wr_accept  = awvalid & wvalid & ~bvalid; // addr and data together
	assign awready    = wr_accept;
	assign wready     = wr_accept;
	assign wr_control = (awaddr == reg_control);
	assign wr_dip     = (awaddr == reg_dip);

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			bvalid        <= 1'b0;
			turbo_request <= 1'b0;
			dip_sw        <= dip_default;
			soft_reset    <= 1'b0;
		end else begin
			soft_reset <= wr_accept & wr_control & wstrb[0] & wdata[1]; // not stored
			if (wr_accept) begin
				bvalid <= 1'b1;
				if (wr_control && wstrb[0])
					turbo_request <= wdata[0];
				if (wr_dip && wstrb[0])
					dip_sw <= wdata[7:0];
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// response payload, held while bvalid waits
	always_ff @(posedge clk_chipset) begin
		if (wr_accept)
			bresp <= (wr_control || wr_dip) ? resp_okay : resp_slverr;
	end

	//////////////////////////////////////////////////
	// read channel
	//////////////////////////////////////////////////

	assign arready   = ~rvalid;
	assign rd_accept = arvalid & ~rvalid;

	always_comb begin
		rd_data   = '0;
		rd_mapped = 1'b1;
		case (araddr)
			reg_control:   rd_data[0] = turbo_request;
			reg_dip:       rd_data[7:0] = dip_sw;
			reg_status: begin
				rd_data[0] = turbo_mode;
				rd_data[1] = cpu_reset;
			end
			reg_mix_level: rd_data = axi_data_w'(mix_level); // zero extended
			default:       rd_mapped = 1'b0; // zero data, slverr
		endcase
	end

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire)
			rvalid <= 1'b0;
		else if (rd_accept)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge clk_chipset) begin
		if (rd_accept) begin
			rdata <= rd_data;
			rresp <= rd_mapped ? resp_okay : resp_slverr;
		end
	end

	//////////////////////////////////////////////////
	// turbo latch and port c
	//////////////////////////////////////////////////

	// only switch speed between bus cycles
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire)
			turbo_mode <= 1'b0;
		else if (biu_done)
			turbo_mode <= turbo_request;
	end

	assign port_c_low = port_b_out[3] ? dip_sw[7:4] : dip_sw[3:0]; // nibble select

endmodule

`default_nettype wire

// ==== design/chipset_glue.sv ====
`timescale 1ns/1ps
`default_nettype none

module chipset_glue
	import pcxt_glue_pkg::*;
#(
	parameter int unsigned reset_hold      = 65535,
	parameter int unsigned cpu_reset_delay = 42,
	parameter int unsigned opl_increment   = 358,   // 3.58 mhz fm enable
	parameter int unsigned opl_modulus     = 5000,
	parameter int unsigned uart_increment  = 14815, // uart 16x clock
	parameter int unsigned uart_modulus    = 50000,
	parameter int unsigned uart_divide     = 8
) (
	input  wire                     clk_chipset,
	input  wire                     reset_wire,
	// axi4-lite slave
	input  wire  [axi_addr_w-1:0]   awaddr,
	input  wire                     awvalid,
	output logic                    awready,
	input  wire  [axi_data_w-1:0]   wdata,
	input  wire  [axi_data_w/8-1:0] wstrb,
	input  wire                     wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  wire                     bready,
	input  wire  [axi_addr_w-1:0]   araddr,
	input  wire                     arvalid,
	output logic                    arready,
	output logic [axi_data_w-1:0]   rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  wire                     rready,
	// chipset core side
	input  wire                     biu_done,
	input  wire  [7:0]              port_b_out,
	input  wire  [sample_w-1:0]     opl_sample,
	input  wire  [sample_w-1:0]     tandy_sample,
	input  wire                     speaker,
	output logic                    sys_reset,
	output logic                    cpu_reset,
	output logic                    opl_clk_en,
	output logic                    uart_clk_en,
	output logic                    turbo_mode,
	output logic [3:0]              port_c_low,
	output logic                    audio_out
);

	logic                soft_reset; // regs to sequencer
	logic [sample_w-1:0] mix_level;  // mixer to regs

	reset_sequencer #(
		.reset_hold      (reset_hold),
		.cpu_reset_delay (cpu_reset_delay)
	) u_reset_sequencer (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.soft_reset  (soft_reset),
		.sys_reset   (sys_reset),
		.cpu_reset   (cpu_reset)
	);

	frac_clock_enable #(
		.increment (opl_increment),
		.modulus   (opl_modulus),
		.divide    (1)
	) u_opl_clk_en (
		.clk_chipset (clk_chipset),
		.sys_reset   (sys_reset),
		.clk_en      (opl_clk_en)
	);

	frac_clock_enable #(
		.increment (uart_increment),
		.modulus   (uart_modulus),
		.divide    (uart_divide)
	) u_uart_clk_en (
		.clk_chipset (clk_chipset),
		.sys_reset   (sys_reset),
		.clk_en      (uart_clk_en)
	);

	audio_mixer_dac u_audio_mixer_dac (
		.clk_chipset  (clk_chipset),
		.sys_reset    (sys_reset),
		.opl_sample   (opl_sample),
		.tandy_sample (tandy_sample),
		.speaker      (speaker),
		.mix_level    (mix_level),
		.audio_out    (audio_out)
	);

	glue_ctrl_regs u_glue_ctrl_regs (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wvalid      (wvalid),
		.wready      (wready),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.rready      (rready),
		.cpu_reset   (cpu_reset),
		.mix_level   (mix_level),
		.biu_done    (biu_done),
		.port_b_out  (port_b_out),
		.soft_reset  (soft_reset),
		.turbo_mode  (turbo_mode),
		.port_c_low  (port_c_low)
	);

endmodule

`default_nettype wire

// ==== tb/chipset_glue_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module chipset_glue_sva (
	input wire        clk_chipset,
	input wire        reset_wire,
	input wire        bvalid,
	input wire        bready,
	input wire [1:0]  bresp,
	input wire        rvalid,
	input wire        rready,
	input wire [31:0] rdata,
	input wire [1:0]  rresp,
	input wire        sys_reset,
	input wire        cpu_reset,
	input wire        opl_clk_en,
	input wire        uart_clk_en
);

	//////////////////////////////////////////////////
	// axi response channels
	//////////////////////////////////////////////////

	bvalid_hold: assert property (@(posedge clk_chipset) disable iff (reset_wire)
		bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");

	bresp_stable: assert property (@(posedge clk_chipset) disable iff (reset_wire)
		bvalid && !bready |=> $stable(bresp)) else $error("bresp changed while waiting");

	rvalid_hold: assert property (@(posedge clk_chipset) disable iff (reset_wire)
		rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

	rdata_stable: assert property (@(posedge clk_chipset) disable iff (reset_wire)
		rvalid && !rready |=> $stable(rdata) && $stable(rresp))
		else $error("read payload changed while waiting");

	//////////////////////////////////////////////////
	// reset ordering
	//////////////////////////////////////////////////

	cpu_parked: assert property (@(posedge clk_chipset) disable iff (reset_wire)
		sys_reset |-> cpu_reset) else $error("cpu_reset low during sys_reset");

	enables_quiet: assert property (@(posedge clk_chipset) disable iff (reset_wire)
		sys_reset |-> !opl_clk_en && !uart_clk_en) // no enables in reset
		else $error("clock enable during sys_reset");

endmodule

bind chipset_glue chipset_glue_sva sva_i (
	.clk_chipset (clk_chipset),
	.reset_wire  (reset_wire),
	.bvalid      (bvalid),
	.bready      (bready),
	.bresp       (bresp),
	.rvalid      (rvalid),
	.rready      (rready),
	.rdata       (rdata),
	.rresp       (rresp),
	.sys_reset   (sys_reset),
	.cpu_reset   (cpu_reset),
	.opl_clk_en  (opl_clk_en),
	.uart_clk_en (uart_clk_en)
);

`default_nettype wire

// ==== tb/chipset_glue_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module chipset_glue_tb
	import pcxt_glue_pkg::*;
;

	localparam int tb_reset_hold = 64;
	localparam int tb_cpu_delay  = 42;
	localparam int seq_len       = tb_reset_hold + tb_cpu_delay + 1; // edges to cpu release
	localparam int enable_cycles = 20000;
	localparam int settle_cycles = 1024;
	localparam int duty_cycles   = 4096;
	// sum of the test lengths plus margin
	localparam int watchdog_cycles = 5 + 4 * seq_len + enable_cycles
		+ 2 * (settle_cycles + duty_cycles) + 8000;

	logic clk_chipset = 1'b0;
	logic reset_wire;
	logic [axi_addr_w-1:0] awaddr, araddr;
	logic awvalid, wvalid, bready, arvalid, rready;
	logic [axi_data_w-1:0] wdata;
	logic [axi_data_w/8-1:0] wstrb;
	logic awready, wready, bvalid, arready, rvalid;
	logic [1:0] bresp, rresp;
	logic [axi_data_w-1:0] rdata;
	logic biu_done, speaker;
	logic [7:0] port_b_out;
	logic [sample_w-1:0] opl_sample, tandy_sample;
	logic sys_reset, cpu_reset, opl_clk_en, uart_clk_en, turbo_mode, audio_out;
	logic [3:0] port_c_low;

	int errors = 0;
	int checks = 0;
	int tests  = 0;
	int test_err_start;
	logic [31:0] lcg_state = 32'hb5a02d83;

	always #50 clk_chipset = ~clk_chipset; // 100 ns period

	chipset_glue #(
		.reset_hold      (tb_reset_hold),
		.cpu_reset_delay (tb_cpu_delay)
	) dut (.*);

	// watchdog
	initial begin
		repeat (watchdog_cycles) @(posedge clk_chipset);
		$display("watchdog expired before the tests finished");
		$display("Test failures found");
		$finish;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input longint got, input longint exp);
		checks++;
		assert (got == exp) else begin
			$display("ERR t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic fail_plain(input string what);
		$display("t=%0t %s", $time, what);
		errors++;
	endtask

	task automatic begin_test();
		tests++;
		test_err_start = errors;
	endtask

	task automatic end_test(input string name);
		$display("test %0d %s: %s", tests, name, (errors == test_err_start) ? "ok" : "FAILED");
	endtask

	////////////////////////////////////////////////////
	// axi master tasks
	////////////////////////////////////////////////////

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int n;
		@(posedge clk_chipset);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		n = 0;
		do begin
			@(negedge clk_chipset);
			n++;
		end while (!(awready && wready) && n < 200); // stalls while old response waits
		if (!(awready && wready))
			fail_plain("write address and data never accepted together");
		@(posedge clk_chipset);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		n = 0;
		do begin
			@(negedge clk_chipset);
			n++;
		end while (!bvalid && n < 200);
		if (!bvalid)
			fail_plain("write response never arrived");
		resp = bresp;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int n;
		@(posedge clk_chipset);
		araddr  <= addr;
		arvalid <= 1'b1;
		n = 0;
		do begin
			@(negedge clk_chipset);
			n++;
		end while (!arready && n < 200);
		if (!arready)
			fail_plain("read address never accepted");
		@(posedge clk_chipset);
		arvalid <= 1'b0;
		n = 0;
		do begin
			@(negedge clk_chipset);
			n++;
		end while (!rvalid && n < 200);
		if (!rvalid)
			fail_plain("read data never arrived");
		data = rdata;
		resp = rresp;
	endtask

	// posedges until cpu_reset is seen low
	task automatic count_to_cpu_release(output int n);
		n = 0;
		do begin
			@(posedge clk_chipset);
			n++;
			@(negedge clk_chipset);
		end while (cpu_reset && n < 4 * seq_len);
	endtask

	task automatic wait_sys_reset(input logic level);
		int n;
		n = 0;
		do begin
			@(negedge clk_chipset);
			n++;
		end while (sys_reset != level && n < 4 * seq_len);
		if (sys_reset != level)
			fail_plain("sys_reset never reached the expected level");
	endtask

	// signed 17 bit sum, then clamp to 16 bits
	function automatic logic [15:0] mix_model(input logic [15:0] o, input logic [15:0] t,
		input logic s);
		int full;
		logic signed [16:0] s17;
		int v;
		full = 2 * int'($signed(o)) + 64 * int'($signed(t)) + (s ? 8192 : 0);
		s17  = full[16:0];
		v    = s17;
		if (v > 32767)
			v = 32767;
		else if (v < -32768)
			v = -32768;
		return v[15:0];
	endfunction

	task automatic measure_duty(input logic [15:0] opl);
		int high;
		longint expect_high;
		logic [15:0] lvl;
		@(posedge clk_chipset);
		opl_sample   <= opl;
		tandy_sample <= '0;
		speaker      <= 1'b0;
		lvl = mix_model(opl, 16'd0, 1'b0);
		expect_high = longint'({~lvl[15], lvl[14:0]}) * duty_cycles / 65536;
		repeat (settle_cycles) @(negedge clk_chipset);
		high = 0;
		repeat (duty_cycles) begin
			@(negedge clk_chipset);
			high += audio_out;
		end
		checks++;
		assert (high >= expect_high - duty_cycles / 50 && high <= expect_high + duty_cycles / 50)
		else begin
			$display("ERR t=%0t audio_out high count: got %0d, expected %0d", $time, high,
				expect_high);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////

	initial begin
		logic [31:0] d;
		logic [1:0] r;
		int n;
		int opl_cnt;
		int uart_cnt;
		logic [7:0] sw;
		logic [15:0] o, t;
		logic s;

		reset_wire   <= 1'b1;
		awaddr       <= '0;
		awvalid      <= 1'b0;
		wdata        <= '0;
		wstrb        <= 4'hF;
		wvalid       <= 1'b0;
		bready       <= 1'b1;
		araddr       <= '0;
		arvalid      <= 1'b0;
		rready       <= 1'b1;
		biu_done     <= 1'b0;
		port_b_out   <= '0;
		opl_sample   <= '0;
		tandy_sample <= '0;
		speaker      <= 1'b0;
		repeat (5) @(posedge clk_chipset);
		reset_wire <= 1'b0;

		// 1. board reset then soft reset
		begin_test();
		count_to_cpu_release(n);
		check_value("cpu_reset release edges", n, seq_len);
		axi_write(reg_control, 32'h2, r);
		check_value("bresp control", r, resp_okay);
		wait_sys_reset(1'b1);
		check_value("cpu_reset on soft reset", cpu_reset, 1);
		count_to_cpu_release(n);
		check_value("cpu_reset soft release edges", n, seq_len);
		axi_write(reg_control, 32'h2, r);
		axi_read(reg_status, d, r);
		check_value("status cpu_reset bit", d[1], 1); // still parked
		end_test("reset timing");

		// 2. fractional enables, counted from sys_reset release
		begin_test();
		wait_sys_reset(1'b0);
		opl_cnt  = 0;
		uart_cnt = 0;
		repeat (enable_cycles) begin
			@(negedge clk_chipset);
			opl_cnt  += opl_clk_en;
			uart_cnt += uart_clk_en;
		end
		check_value("opl_clk_en count", opl_cnt, longint'(enable_cycles) * 358 / 5000);
		check_value("uart_clk_en count", uart_cnt,
			(longint'(enable_cycles) * 14815 / 50000) / 8);
		end_test("clock enables");

		// 3. register map
		begin_test();
		axi_read(reg_dip, d, r);
		check_value("dip default", d, dip_default);
		axi_write(reg_dip, 32'hA5, r);
		check_value("bresp dip", r, resp_okay);
		axi_read(reg_dip, d, r);
		check_value("dip readback", d, 32'hA5);
		axi_read(reg_status, d, r);
		check_value("status cpu_reset bit", d[1], 0); // cpu running by now
		axi_write(reg_status, 32'hFF, r);
		check_value("bresp status write", r, resp_slverr);
		axi_write(reg_mix_level, 32'hFF, r);
		check_value("bresp mix write", r, resp_slverr);
		axi_write(4'h2, 32'hFF, r);
		check_value("bresp unmapped write", r, resp_slverr);
		axi_read(4'hD, d, r);
		check_value("rresp unmapped", r, resp_slverr);
		check_value("rdata unmapped", d, 0);
		axi_read(reg_dip, d, r);
		check_value("dip after bad writes", d, 32'hA5);
		// responses wait under back-pressure
		@(posedge clk_chipset);
		bready <= 1'b0;
		axi_write(reg_dip, 32'h3C, r);
		repeat (4) begin
			@(negedge clk_chipset);
			check_value("bvalid held", bvalid, 1);
		end
		@(posedge clk_chipset);
		bready <= 1'b1;
		axi_write(reg_dip, 32'h5A, r);
		@(posedge clk_chipset);
		rready <= 1'b0;
		axi_read(reg_dip, d, r);
		repeat (4) begin
			@(negedge clk_chipset);
			check_value("rvalid held", rvalid, 1);
			check_value("rdata held", rdata, 32'h5A);
		end
		@(posedge clk_chipset);
		rready <= 1'b1;
		end_test("register map");

		// 4. turbo latch and port c
		begin_test();
		axi_write(reg_control, 32'h1, r);
		repeat (5) begin
			@(negedge clk_chipset);
			check_value("turbo_mode before biu_done", turbo_mode, 0);
		end
		@(posedge clk_chipset);
		biu_done <= 1'b1;
		@(negedge clk_chipset);
		check_value("turbo_mode same cycle", turbo_mode, 0);
		@(posedge clk_chipset);
		biu_done <= 1'b0;
		@(negedge clk_chipset);
		check_value("turbo_mode after biu_done", turbo_mode, 1);
		axi_read(reg_status, d, r);
		check_value("status turbo bit", d[0], 1);
		for (int i = 0; i < 8; i++) begin
			lcg_state = lcg_next(lcg_state);
			sw = lcg_state[23:16];
			axi_write(reg_dip, {24'd0, sw}, r);
			@(posedge clk_chipset);
			port_b_out <= lcg_state[7:0] & 8'hF7;
			@(negedge clk_chipset);
			check_value("port_c_low low nibble", port_c_low, sw[3:0]);
			@(posedge clk_chipset);
			port_b_out <= lcg_state[7:0] | 8'h08;
			@(negedge clk_chipset);
			check_value("port_c_low high nibble", port_c_low, sw[7:4]);
		end
		end_test("turbo and port c");

		// 5. mixer clamp and sigma-delta duty
		begin_test();
		for (int i = 0; i < 24; i++) begin
			lcg_state = lcg_next(lcg_state);
			o = lcg_state[31:16];
			lcg_state = lcg_next(lcg_state);
			t = (i % 3 == 0) ? {{5{lcg_state[31]}}, lcg_state[26:16]} : lcg_state[31:16];
			s = lcg_state[5];
			if (i == 0) begin // full scale corners
				o = 16'h7FFF;
				t = 16'h01FF;
			end else if (i == 1) begin
				o = 16'h8000;
				t = 16'hFE00;
			end
			@(posedge clk_chipset);
			opl_sample   <= o;
			tandy_sample <= t;
			speaker      <= s;
			axi_read(reg_mix_level, d, r);
			check_value("mix_level", d, {16'd0, mix_model(o, t, s)});
		end
		measure_duty(16'h2000);
		measure_duty(16'hE890);
		end_test("mixer");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/pcxt_glue_pkg.sv
design/reset_sequencer.sv
design/frac_clock_enable.sv
design/audio_mixer_dac.sv
design/glue_ctrl_regs.sv
design/chipset_glue.sv
tb/chipset_glue_sva.sv
tb/chipset_glue_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= chipset_glue_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed!" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
